/* include/vdp_macros.svh */
/*
 * Raster timing and VRAM geometry for the video display processor.
 * Included by the timing generator, the line fetcher, the package and the checker.
 */
`ifndef VDP_MACROS_SVH
`define VDP_MACROS_SVH

// Horizontal segments, in clocks.
`define VDP_H_ACTIVE 16
`define VDP_H_FP     2
`define VDP_H_SYNC   4
`define VDP_H_BP     10

// Vertical segments, in lines.
`define VDP_V_ACTIVE 8
`define VDP_V_FP     1
`define VDP_V_SYNC   2
`define VDP_V_BP     3

// VRAM word address width. Four pixels per word.
`define VDP_VRAM_AW  5

`endif

/* design/vdp_pkg.sv */
/*
 * Shared types of the video display processor.
 * Modules import it in their body and use scoped names in their port lists.
 */
`include "vdp_macros.svh"

package vdp_pkg;

    // One RGB332 pixel.
    typedef logic [7:0] pixel_t;

    // Four pixels per word; the pixel at column c sits in element c mod 4.
    typedef pixel_t [3:0] vram_word_t;

    // Word address is line * 4 + column / 4.
    typedef logic [`VDP_VRAM_AW-1:0] vram_addr_t;

    // Raster coordinates, wide enough for a 32-clock line and a 14-line frame.
    typedef logic [5:0] raster_x_t;
    typedef logic [3:0] raster_y_t;

endpackage

/* design/vdp_wb_if.sv */
/*
 * Wishbone classic bus between the fetcher, the host port, the arbiter and the VRAM.
 * A master holds its request until ack, which is high for one cycle per transfer.
 */
interface vdp_wb_if;
    import vdp_pkg::*;

    logic       cyc;
    logic       stb;
    logic       we;
    vram_addr_t adr;
    vram_word_t dat_w;
    vram_word_t dat_r;
    logic [3:0] sel;   // One enable per pixel byte.
    logic       ack;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack
    );

endinterface

/* design/vdp_vga_timing.sv */
/*
 * Raster timing generator. Walks each line and each frame through front porch,
 * sync, back porch and active segments, one raster position per clock.
 * Syncs, display enable and strobes are registered and line up with raster_x/raster_y.
 */
`include "vdp_macros.svh"

module vdp_vga_timing (
    input  logic               clk,
    input  logic               arst_n,
    output vdp_pkg::raster_x_t raster_x,
    output vdp_pkg::raster_y_t raster_y,
    output logic               line_start,
    output logic               frame_start,
    output logic               hsync,
    output logic               vsync,
    output logic               active
);
    import vdp_pkg::*;

    typedef enum logic [1:0] {
        SEG_FP     = 2'd0,
        SEG_SYNC   = 2'd1,
        SEG_BP     = 2'd2,
        SEG_ACTIVE = 2'd3
    } seg_t;

    localparam int H_TOTAL = `VDP_H_FP + `VDP_H_SYNC + `VDP_H_BP + `VDP_H_ACTIVE;
    localparam int V_TOTAL = `VDP_V_ACTIVE + `VDP_V_FP + `VDP_V_SYNC + `VDP_V_BP;

    seg_t      x_state;
    seg_t      x_state_nx;
    seg_t      y_state;
    seg_t      y_state_nx;
    raster_x_t x_end;
    raster_x_t raster_x_nx;
    raster_y_t y_end;
    raster_y_t raster_y_nx;
    logic      line_end;
    logic      frame_end;

    // Last position of the current horizontal segment.
    always_comb begin
        case (x_state)
            SEG_FP:   x_end = raster_x_t'(`VDP_H_FP - 1);
            SEG_SYNC: x_end = raster_x_t'(`VDP_H_FP + `VDP_H_SYNC - 1);
            SEG_BP:   x_end = raster_x_t'(`VDP_H_FP + `VDP_H_SYNC + `VDP_H_BP - 1);
            default:  x_end = raster_x_t'(H_TOTAL - 1);
        endcase
    end

    // The frame starts with active lines, then the vertical blanking.
    always_comb begin
        case (y_state)
            SEG_ACTIVE: y_end = raster_y_t'(`VDP_V_ACTIVE - 1);
            SEG_FP:     y_end = raster_y_t'(`VDP_V_ACTIVE + `VDP_V_FP - 1);
            SEG_SYNC:   y_end = raster_y_t'(`VDP_V_ACTIVE + `VDP_V_FP + `VDP_V_SYNC - 1);
            default:    y_end = raster_y_t'(V_TOTAL - 1);
        endcase
    end

    assign line_end  = (x_state == SEG_ACTIVE) && (raster_x == x_end);
    assign frame_end = line_end && (y_state == SEG_BP) && (raster_y == y_end);

    always_comb begin
        x_state_nx  = x_state;
        raster_x_nx = raster_x + 1'b1;
        if (raster_x == x_end) begin
            x_state_nx = seg_t'(x_state + 2'd1); // Active wraps back to front porch.
        end
        if (line_end) begin
            raster_x_nx = '0;
        end
    end

    always_comb begin
        y_state_nx  = y_state;
        raster_y_nx = raster_y;
        if (line_end) begin
            raster_y_nx = frame_end ? raster_y_t'(0) : raster_y + 1'b1;
            if (raster_y == y_end) begin
                y_state_nx = seg_t'(y_state + 2'd1);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_state     <= SEG_FP;
            y_state     <= SEG_ACTIVE;
            raster_x    <= '0;
            raster_y    <= '0;
            hsync       <= 1'b1;
            vsync       <= 1'b1;
            active      <= 1'b0;
            line_start  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            x_state     <= x_state_nx;
            y_state     <= y_state_nx;
            raster_x    <= raster_x_nx;
            raster_y    <= raster_y_nx;
            hsync       <= (x_state_nx != SEG_SYNC); // Registered from next state to stay aligned.
            vsync       <= (y_state_nx != SEG_SYNC);
            active      <= (x_state_nx == SEG_ACTIVE) && (y_state_nx == SEG_ACTIVE);
            line_start  <= line_end;
            frame_start <= frame_end;
        end
    end

endmodule

/* design/vdp_vram_arbiter.sv */
/*
 * Shares the single VRAM port between the line fetcher and the host.
 * A grant is taken on an idle bus, fetcher first, and held until the RAM acks.
 */
module vdp_vram_arbiter (
    input logic      clk,
    input logic      arst_n,
    vdp_wb_if.slave  fetch,
    vdp_wb_if.slave  host,
    vdp_wb_if.master ram
);

    logic granted;
    logic grant_fetch;   // Which master owns the bus while granted is high.
    logic fetch_req;
    logic host_req;

    assign fetch_req = fetch.cyc && fetch.stb;
    assign host_req  = host.cyc && host.stb;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            granted     <= 1'b0;
            grant_fetch <= 1'b0;
        end else if (!granted) begin
            if (fetch_req) begin
                granted     <= 1'b1;
                grant_fetch <= 1'b1;
            end else if (host_req) begin
                granted     <= 1'b1;
                grant_fetch <= 1'b0;
            end
        end else if (ram.ack) begin
            granted <= 1'b0; // Bus goes idle for one clock before the next decision.
        end
    end

    // Request path to the RAM follows the grant.
    always_comb begin
        if (grant_fetch) begin
            ram.cyc   = granted && fetch.cyc;
            ram.stb   = granted && fetch.stb;
            ram.we    = fetch.we;
            ram.adr   = fetch.adr;
            ram.dat_w = fetch.dat_w;
            ram.sel   = fetch.sel;
        end else begin
            ram.cyc   = granted && host.cyc;
            ram.stb   = granted && host.stb;
            ram.we    = host.we;
            ram.adr   = host.adr;
            ram.dat_w = host.dat_w;
            ram.sel   = host.sel;
        end
    end

    // Responses go only to the owner.
    assign fetch.ack   = granted && grant_fetch && ram.ack;
    assign host.ack    = granted && !grant_fetch && ram.ack;
    assign fetch.dat_r = grant_fetch ? ram.dat_r : '0;
    assign host.dat_r  = grant_fetch ? '0 : ram.dat_r;

endmodule

/* design/vdp_vram.sv */
/*
 * Video RAM of 32 words on a Wishbone classic slave port.
 * Byte-lane writes by sel; read data and ack are registered, one clock after the request.
 */
module vdp_vram (
    input logic     clk,
    input logic     arst_n,
    vdp_wb_if.slave bus
);
    import vdp_pkg::*;

    localparam int DEPTH = 2 ** $bits(vram_addr_t);

    vram_word_t mem [DEPTH];
    logic       req;

    // Only the first cycle of a transfer is a new request.
    assign req = bus.cyc && bus.stb && !bus.ack;

    always_ff @(posedge clk) begin
        if (req) begin
            if (bus.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (bus.sel[i]) begin
                        mem[bus.adr][i] <= bus.dat_w[i];
                    end
                end
            end
            bus.dat_r <= mem[bus.adr]; // A write returns the old word.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req;
        end
    end

endmodule

/* design/vdp_line_fetch.sv */
/*
 * Line fetcher. At each active line start it reads the line's four VRAM words
 * into a buffer, then shifts them out as pixels during the active part.
 * Pixel, de and the syncs leave through one register stage, one clock behind the timing.
 */
`include "vdp_macros.svh"

module vdp_line_fetch (
    input  logic               clk,
    input  logic               arst_n,
    input  vdp_pkg::raster_x_t raster_x,
    input  vdp_pkg::raster_y_t raster_y,
    input  logic               line_start,
    input  logic               hsync,
    input  logic               vsync,
    input  logic               active,
    vdp_wb_if.master           bus,
    output vdp_pkg::pixel_t    pixel,
    output logic               de,
    output logic               hsync_out,
    output logic               vsync_out
);
    import vdp_pkg::*;

    localparam int H_OFFSCREEN = `VDP_H_FP + `VDP_H_SYNC + `VDP_H_BP;
    localparam int LINE_WORDS  = `VDP_H_ACTIVE / 4;

    vram_word_t line_buf [LINE_WORDS];
    logic       fetch_busy;
    logic [1:0] fetch_idx;
    raster_x_t  col;

    // Read-only master.
    assign bus.cyc   = fetch_busy;
    assign bus.stb   = fetch_busy;
    assign bus.we    = 1'b0;
    assign bus.sel   = 4'hf;
    assign bus.dat_w = '0;
    assign bus.adr   = {raster_y[`VDP_VRAM_AW-3:0], fetch_idx}; // Line * 4 + word.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_busy <= 1'b0;
            fetch_idx  <= '0;
        end else if (fetch_busy) begin
            if (bus.ack) begin
                fetch_idx <= fetch_idx + 2'd1;
                if (fetch_idx == 2'(LINE_WORDS - 1)) begin
                    fetch_busy <= 1'b0;
                end
            end
        end else if (line_start && (raster_y < `VDP_V_ACTIVE)) begin
            fetch_busy <= 1'b1;
            fetch_idx  <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.ack) begin
            line_buf[fetch_idx] <= bus.dat_r;
        end
    end

    // Column within the active part of the line.
    assign col = raster_x - raster_x_t'(H_OFFSCREEN);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pixel     <= '0;
            de        <= 1'b0;
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
        end else begin
            pixel     <= active ? line_buf[col[3:2]][col[1:0]] : pixel_t'(0); // Black in blanking.
            de        <= active;
            hsync_out <= hsync;
            vsync_out <= vsync;
        end
    end

endmodule

/* design/vdp_top.sv */
/*
 * Video display processor top level. Raster timing, line fetcher, VRAM arbiter
 * and VRAM, with the host Wishbone bus and the video outputs on plain ports.
 */
module vdp_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                host_cyc,
    input  logic                host_stb,
    input  logic                host_we,
    input  vdp_pkg::vram_addr_t host_adr,
    input  logic [3:0]          host_sel,
    input  vdp_pkg::vram_word_t host_dat_w,
    output vdp_pkg::vram_word_t host_dat_r,
    output logic                host_ack,
    output vdp_pkg::pixel_t     pixel,
    output logic                de,
    output logic                hsync,
    output logic                vsync
);

    vdp_pkg::raster_x_t raster_x;
    vdp_pkg::raster_y_t raster_y;
    logic               line_start;
    logic               tim_hsync;
    logic               tim_vsync;
    logic               tim_active;

    vdp_wb_if fetch_bus ();
    vdp_wb_if host_bus ();
    vdp_wb_if ram_bus ();

    // Host pins drive the master side of host_bus.
    assign host_bus.cyc   = host_cyc;
    assign host_bus.stb   = host_stb;
    assign host_bus.we    = host_we;
    assign host_bus.adr   = host_adr;
    assign host_bus.sel   = host_sel;
    assign host_bus.dat_w = host_dat_w;
    assign host_dat_r     = host_bus.dat_r;
    assign host_ack       = host_bus.ack;

    vdp_vga_timing u_timing (
        .clk         (clk),
        .arst_n      (arst_n),
        .raster_x    (raster_x),
        .raster_y    (raster_y),
        .line_start  (line_start),
        .frame_start (),
        .hsync       (tim_hsync),
        .vsync       (tim_vsync),
        .active      (tim_active)
    );

    vdp_line_fetch u_line_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .raster_x   (raster_x),
        .raster_y   (raster_y),
        .line_start (line_start),
        .hsync      (tim_hsync),
        .vsync      (tim_vsync),
        .active     (tim_active),
        .bus        (fetch_bus.master),
        .pixel      (pixel),
        .de         (de),
        .hsync_out  (hsync),
        .vsync_out  (vsync)
    );

    vdp_vram_arbiter u_arbiter (
        .clk    (clk),
        .arst_n (arst_n),
        .fetch  (fetch_bus.slave),
        .host   (host_bus.slave),
        .ram    (ram_bus.master)
    );

    vdp_vram u_vram (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (ram_bus.slave)
    );

endmodule

/* verif/vdp_checker.sv */
/*
 * Checker for the video display processor testbench. Follows the raster from one
 * clock after reset, mirrors acknowledged host writes into a model VRAM and compares
 * syncs, display enable, pixels and host reads. The testbench calls its test tasks.
 */
`include "vdp_macros.svh"

module vdp_checker (
    input logic                clk,
    input logic                arst_n,
    input logic                host_cyc,
    input logic                host_stb,
    input logic                host_we,
    input vdp_pkg::vram_addr_t host_adr,
    input logic [3:0]          host_sel,
    input vdp_pkg::vram_word_t host_dat_w,
    input vdp_pkg::vram_word_t host_dat_r,
    input logic                host_ack,
    input vdp_pkg::pixel_t     pixel,
    input logic                de,
    input logic                hsync,
    input logic                vsync
);
    timeunit 1ns;
    timeprecision 1ns;
    import vdp_pkg::*;

    localparam int H_BLANK   = `VDP_H_FP + `VDP_H_SYNC + `VDP_H_BP;
    localparam int V_SYNC_LO = `VDP_V_ACTIVE + `VDP_V_FP;
    localparam int V_TOTAL   = V_SYNC_LO + `VDP_V_SYNC + `VDP_V_BP;
    localparam int WORDS     = 2 ** `VDP_VRAM_AW;

    vram_word_t model_mem [WORDS];
    vram_word_t shown_mem [WORDS];   // The model as it stood when the frame began.
    logic [3:0] model_valid [WORDS];
    logic [3:0] shown_valid [WORDS];
    logic       req_we;
    vram_addr_t req_adr;
    logic [3:0] req_sel;
    vram_word_t req_dat;
    logic       live;
    int         cx;
    int         cy;
    int         px;
    int         word;
    string      test_name = "reset";
    int         test_errors;
    int         test_pixels;
    int         tests_run;
    int         tests_failed;
    int         checks;
    int         errors;

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            model_valid[i] = 4'h0;
        end
    end

    // Reference: byte x mod 4 of word y * 4 + x / 4.
    function automatic pixel_t expected_pixel(input int x, input int y);
        vram_word_t w;
        w = shown_mem[y * (`VDP_H_ACTIVE / 4) + x / 4];
        return w[x % 4];
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("Error in %s: %s expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        test_errors++;
        $display("Failure in %s: %s", test_name, msg);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_pixels = 0;
    endtask

    task automatic end_test(input int min_pixels);
        if (test_pixels < min_pixels) begin
            report_failure($sformatf("only %0d of %0d pixels were compared", test_pixels,
                                     min_pixels));
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: passed, %0d pixels compared", test_name, test_pixels);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    // The request is still held at the clock edge that raises ack.
    always @(posedge clk) begin
        if (host_cyc && host_stb) begin
            req_we  <= host_we;
            req_adr <= host_adr;
            req_sel <= host_sel;
            req_dat <= host_dat_w;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    always @(negedge clk) begin
        if (host_ack && req_we) begin
            for (int i = 0; i < 4; i++) begin
                if (req_sel[i]) begin
                    model_mem[req_adr][i]   = req_dat[i];
                    model_valid[req_adr][i] = 1'b1;
                end
            end
        end else if (host_ack && model_valid[req_adr] != 4'hf) begin
            report_failure($sformatf("host read word %0d before it was written", req_adr));
        end else if (host_ack) begin
            compare($sformatf("read of word %0d", req_adr), model_mem[req_adr], host_dat_r);
        end
        if (!live) begin
            cx = 0;
            cy = 0;
        end else begin
            if (cx == 0 && cy == 0) begin
                for (int i = 0; i < WORDS; i++) begin
                    shown_mem[i]   = model_mem[i];
                    shown_valid[i] = model_valid[i];
                end
            end
            compare($sformatf("hsync at (%0d,%0d)", cx, cy),
                    !(cx >= `VDP_H_FP && cx < `VDP_H_FP + `VDP_H_SYNC), hsync);
            compare($sformatf("vsync at (%0d,%0d)", cx, cy),
                    !(cy >= V_SYNC_LO && cy < V_SYNC_LO + `VDP_V_SYNC), vsync);
            compare($sformatf("de at (%0d,%0d)", cx, cy),
                    cx >= H_BLANK && cy < `VDP_V_ACTIVE, de);
            if (cx >= H_BLANK && cy < `VDP_V_ACTIVE) begin
                px   = cx - H_BLANK;
                word = cy * (`VDP_H_ACTIVE / 4) + px / 4;
                if (shown_valid[word][px % 4]) begin   // Skip pixels the host never wrote.
                    test_pixels++;
                    compare($sformatf("pixel at (%0d,%0d)", px, cy),
                            expected_pixel(px, cy), pixel);
                end
            end
            cx = (cx == H_BLANK + `VDP_H_ACTIVE - 1) ? 0 : cx + 1;
            if (cx == 0) begin
                cy = (cy == V_TOTAL - 1) ? 0 : cy + 1;
            end
        end
    end

endmodule

/* verif/vdp_tb.sv */
/*
 * Top-level testbench for the video display processor. Drives the host Wishbone
 * port on falling clock edges through the fill, frame, readback and update tests.
 * The checker instance compares everything and keeps the counts.
 */
`include "vdp_macros.svh"

module vdp_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import vdp_pkg::*;

    localparam int FRAME_CYCLES = (`VDP_H_FP + `VDP_H_SYNC + `VDP_H_BP + `VDP_H_ACTIVE)
                                * (`VDP_V_ACTIVE + `VDP_V_FP + `VDP_V_SYNC + `VDP_V_BP);
    localparam int CYCLE_LIMIT  = 6 * FRAME_CYCLES + 2000;
    localparam int ACK_LIMIT    = 40;   // Covers a whole fetch burst ahead of the host.
    localparam int FULL_FRAME   = `VDP_H_ACTIVE * `VDP_V_ACTIVE;

    logic        clk;
    logic        arst_n;
    logic        host_cyc;
    logic        host_stb;
    logic        host_we;
    vram_addr_t  host_adr;
    logic [3:0]  host_sel;
    vram_word_t  host_dat_w;
    vram_word_t  host_dat_r;
    logic        host_ack;
    pixel_t      pixel;
    logic        de;
    logic        hsync;
    logic        vsync;
    logic [31:0] rng;
    vram_addr_t  addr;
    int          cycles;

    vdp_top u_vdp_top (.*);

    vdp_checker u_checker (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    task automatic await_ack(input string what);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!host_ack && waited < ACK_LIMIT);
        if (!host_ack) begin
            u_checker.report_failure({"host ", what, " was never acknowledged"});
        end
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic write_word(input vram_addr_t adr, input vram_word_t data, input logic [3:0] sel);
        host_adr   = adr;
        host_dat_w = data;
        host_sel   = sel;
        host_we    = 1'b1;
        host_cyc   = 1'b1;
        host_stb   = 1'b1;
        await_ack($sformatf("write to word %0d", adr));
    endtask

    task automatic read_word(input vram_addr_t adr);
        host_adr = adr;
        host_sel = 4'hf;
        host_we  = 1'b0;
        host_cyc = 1'b1;
        host_stb = 1'b1;
        await_ack($sformatf("read of word %0d", adr));
    endtask

    // Returns on a falling edge in line 9, with five blank lines ahead.
    task automatic wait_vblank();
        @(negedge vsync);
        @(negedge clk);
    endtask

    task automatic wait_display();
        @(posedge de);
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles before the tests finished", cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        arst_n     = 1'b0;
        host_cyc   = 1'b0;
        host_stb   = 1'b0;
        host_we    = 1'b0;
        host_adr   = '0;
        host_sel   = 4'h0;
        host_dat_w = '0;
        rng        = 32'h6b75;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        u_checker.begin_test("fill");
        wait_vblank();
        for (int w = 0; w < 2 ** `VDP_VRAM_AW; w++) begin
            rng = xorshift32(rng);
            write_word(vram_addr_t'(w), rng, 4'hf);
        end
        u_checker.end_test(0);

        u_checker.begin_test("frame check");
        wait_vblank();
        u_checker.end_test(FULL_FRAME);

        u_checker.begin_test("readback");
        wait_display();   // Reads now compete with the line fetches.
        repeat (40) begin
            rng = xorshift32(rng);
            read_word(vram_addr_t'(rng));
        end
        u_checker.end_test(0);

        u_checker.begin_test("live update");
        wait_vblank();
        repeat (8) begin
            rng  = xorshift32(rng);
            addr = vram_addr_t'(rng >> 8);
            rng  = xorshift32(rng);
            write_word(addr, rng, 4'hf);
        end
        wait_vblank();
        u_checker.end_test(FULL_FRAME);

        u_checker.begin_test("partial write");
        rng  = xorshift32(rng);
        addr = vram_addr_t'(rng);
        rng  = xorshift32(rng);
        write_word(addr, rng, 4'b0101);
        rng = xorshift32(rng);
        write_word(addr, rng, 4'b1000);
        read_word(addr);
        wait_vblank();
        u_checker.end_test(FULL_FRAME);

        $display("Done: %0d tests, %0d failed, %0d checks, %0d errors", u_checker.tests_run,
                 u_checker.tests_failed, u_checker.checks, u_checker.errors);
        if (u_checker.errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+include
design/vdp_pkg.sv
design/vdp_wb_if.sv
design/vdp_vga_timing.sv
design/vdp_vram_arbiter.sv
design/vdp_vram.sv
design/vdp_line_fetch.sv
design/vdp_top.sv
verif/vdp_checker.sv
verif/vdp_tb.sv
